/* rtl/cpu_pkg.sv */
package cpu_pkg;

    localparam int ADDR_W = 6;
    localparam int DATA_W = 16;
    localparam int OPND_W = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    typedef enum logic [3:0] {
        MOV  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        MUL  = 4'd3,
        IN   = 4'd7,
        OUT  = 4'd8,
        STOP = 4'd15
    } opcode_t;

    // Instruction field positions
    localparam int OPC_LSB = 12;
    localparam int X_LSB   = 8;
    localparam int Y_LSB   = 4;
    localparam int Z_LSB   = 0;

    function automatic opcode_t get_opcode(data_t w);
        return opcode_t'(w[OPC_LSB +: 4]);
    endfunction

    // Mode bit sits just above its 3-bit address
    function automatic logic get_mode(data_t w, int lsb);
        return w[lsb + OPND_W];
    endfunction

    function automatic logic [OPND_W-1:0] get_addr(data_t w, int lsb);
        return w[lsb +: OPND_W];
    endfunction

    typedef enum logic [4:0] {
        INIT, FETCH, FETCH_WAIT, FETCH_LOAD, DECODE,
        IND_Z, IND_Z_WAIT, IND_Z_LOAD,
        IND_Y, IND_Y_WAIT, IND_Y_LOAD,
        IND_X, IND_X_WAIT, IND_X_LOAD,
        LOAD_A, LOAD_A_WAIT, LOAD_B, LOAD_B_WAIT,
        EXECUTE, WRITE, IN_WAIT, NEXT, HALT
    } state_t;

    typedef enum logic [1:0] {MAR_PC, MAR_X, MAR_Y, MAR_Z} mar_sel_t;
    typedef enum logic [1:0] {DATA_ALU, DATA_Y, DATA_MDR} mem_data_sel_t;
    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_MUL} alu_op_t;

endpackage

/* rtl/cpu_datapath.sv */
`timescale 1ns/1ps

module cpu_datapath #(
    parameter int PROG_START = 8,
    parameter int PROG_END   = 24
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_pkg::data_t         mem,
    input  cpu_pkg::data_t         in,
    input  logic                   ld_pc,
    input  logic                   inc_pc,
    input  logic                   ld_mar,
    input  logic                   ld_mdr_mem,
    input  logic                   ld_mdr_in,
    input  logic                   ld_ir,
    input  logic                   ld_x,
    input  logic                   ld_y,
    input  logic                   ld_z,
    input  logic                   ld_x_mem,
    input  logic                   ld_y_mem,
    input  logic                   ld_z_mem,
    input  logic                   ld_acc,
    input  logic                   ld_y_alu,
    input  cpu_pkg::mar_sel_t      mar_sel,
    input  cpu_pkg::mem_data_sel_t data_sel,
    input  cpu_pkg::alu_op_t       alu_op,
    input  logic                   addr_strobe,
    input  logic                   write_strobe,
    input  logic                   out_strobe,
    output cpu_pkg::addr_t         addr,
    output cpu_pkg::data_t         data,
    output logic                   we,
    output cpu_pkg::data_t         out,
    output logic                   out_valid,
    output cpu_pkg::addr_t         pc,
    output cpu_pkg::opcode_t       opcode,
    output logic                   mode_x,
    output logic                   mode_y,
    output logic                   mode_z,
    output logic                   z_zero,
    output logic                   prog_done
);
    import cpu_pkg::*;

    addr_t mar;
    addr_t mar_in;
    data_t mdr;
    data_t acc;
    data_t ir;
    data_t x_reg;
    data_t y_reg;
    data_t z_reg;
    data_t alu_res;
    data_t wr_data;
    logic [2*DATA_W-1:0] product;

    // Decoded fields come straight from the instruction register
    assign opcode = get_opcode(ir);
    assign mode_x = get_mode(ir, X_LSB);
    assign mode_y = get_mode(ir, Y_LSB);
    assign mode_z = get_mode(ir, Z_LSB);
    assign z_zero = ({mode_z, get_addr(ir, Z_LSB)} == '0);
    assign prog_done = (pc == addr_t'(PROG_END));

    // Operand registers hold addresses; only the low bits reach MAR
    always_comb begin
        case (mar_sel)
            MAR_PC:  mar_in = pc;
            MAR_X:   mar_in = x_reg[ADDR_W-1:0];
            MAR_Y:   mar_in = y_reg[ADDR_W-1:0];
            default: mar_in = z_reg[ADDR_W-1:0];
        endcase
    end

    // Second operand is taken from the read port in its capture cycle
    assign product = acc * mem;

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_res = acc + mem;
            ALU_SUB: alu_res = acc - mem;
            default: alu_res = product[DATA_W-1:0];
        endcase
    end

    always_comb begin
        case (data_sel)
            DATA_ALU: wr_data = alu_res;
            DATA_Y:   wr_data = y_reg;
            default:  wr_data = mdr;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= addr_t'(PROG_START);
            addr      <= '0;
            data      <= '0;
            we        <= 1'b0;
            out       <= '0;
            out_valid <= 1'b0;
        end else begin
            if (ld_pc) begin
                pc <= addr_t'(PROG_START);
            end else if (inc_pc) begin
                pc <= pc + 1'b1;
            end
            // Address port bypasses MAR when both load together
            if (addr_strobe) begin
                addr <= ld_mar ? mar_in : mar;
            end
            if (write_strobe) begin
                data <= wr_data;
            end
            we <= write_strobe;
            if (out_strobe) begin
                out <= mem;
            end
            out_valid <= out_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_mar) mar <= mar_in;
        if (ld_mdr_mem) begin
            mdr <= mem;
        end else if (ld_mdr_in) begin
            mdr <= in;
        end
        if (ld_ir)  ir  <= mem;
        if (ld_acc) acc <= mem;
        // Decode loads zero-extended field addresses
        if (ld_x) begin
            x_reg <= data_t'(get_addr(ir, X_LSB));
        end else if (ld_x_mem) begin
            x_reg <= mem;
        end
        if (ld_y) begin
            y_reg <= data_t'(get_addr(ir, Y_LSB));
        end else if (ld_y_mem) begin
            y_reg <= mem;
        end else if (ld_y_alu) begin
            y_reg <= alu_res;
        end
        if (ld_z) begin
            z_reg <= data_t'(get_addr(ir, Z_LSB));
        end else if (ld_z_mem) begin
            z_reg <= mem;
        end
    end

endmodule

/* rtl/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   control,
    input  cpu_pkg::opcode_t       opcode,
    input  logic                   mode_x,
    input  logic                   mode_y,
    input  logic                   mode_z,
    input  logic                   z_zero,
    input  logic                   prog_done,
    output logic                   ld_pc,
    output logic                   inc_pc,
    output logic                   ld_mar,
    output logic                   ld_mdr_mem,
    output logic                   ld_mdr_in,
    output logic                   ld_ir,
    output logic                   ld_x,
    output logic                   ld_y,
    output logic                   ld_z,
    output logic                   ld_x_mem,
    output logic                   ld_y_mem,
    output logic                   ld_z_mem,
    output logic                   ld_acc,
    output logic                   ld_y_alu,
    output cpu_pkg::mar_sel_t      mar_sel,
    output cpu_pkg::mem_data_sel_t data_sel,
    output cpu_pkg::alu_op_t       alu_op,
    output logic                   addr_strobe,
    output logic                   write_strobe,
    output logic                   out_strobe,
    output logic                   status,
    output logic                   halted
);
    import cpu_pkg::*;

    state_t state;
    state_t state_next;
    logic   is_arith;
    logic   is_mov;
    logic   after_z;
    logic   after_y;
    logic   after_x;
    state_t ops_state;
    state_t from_x;
    state_t from_y;
    state_t from_z;

    assign is_arith = (opcode == ADD) || (opcode == SUB) || (opcode == MUL);
    assign is_mov   = (opcode == MOV);
    assign after_z  = is_arith && mode_z;
    assign after_y  = (is_arith || is_mov) && mode_y;
    assign after_x  = mode_x;

    // Indirect chain runs z, y, x and skips operands in direct mode
    assign ops_state = (opcode == IN) ? IN_WAIT : LOAD_A;
    assign from_x    = after_x ? IND_X : ops_state;
    assign from_y    = after_y ? IND_Y : from_x;
    assign from_z    = after_z ? IND_Z : from_y;

    assign halted = (state == HALT);

    always_comb begin
        case (opcode)
            SUB:     alu_op = ALU_SUB;
            MUL:     alu_op = ALU_MUL;
            default: alu_op = ALU_ADD;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= INIT;
            status <= 1'b0;
        end else begin
            state  <= state_next;
            // Drops on the edge after control is seen with status high
            status <= (state_next == IN_WAIT) && !(status && control);
        end
    end

    always_comb begin
        state_next   = state;
        ld_pc        = 1'b0;
        inc_pc       = 1'b0;
        ld_mar       = 1'b0;
        ld_mdr_mem   = 1'b0;
        ld_mdr_in    = 1'b0;
        ld_ir        = 1'b0;
        ld_x         = 1'b0;
        ld_y         = 1'b0;
        ld_z         = 1'b0;
        ld_x_mem     = 1'b0;
        ld_y_mem     = 1'b0;
        ld_z_mem     = 1'b0;
        ld_acc       = 1'b0;
        ld_y_alu     = 1'b0;
        mar_sel      = MAR_PC;
        data_sel     = DATA_MDR;
        addr_strobe  = 1'b0;
        write_strobe = 1'b0;
        out_strobe   = 1'b0;

        case (state)
            INIT: begin
                ld_pc      = 1'b1;
                state_next = FETCH;
            end
            FETCH: begin
                ld_mar      = 1'b1;
                addr_strobe = 1'b1;
                inc_pc      = 1'b1;
                state_next  = FETCH_WAIT;
            end
            FETCH_WAIT: state_next = FETCH_LOAD;
            FETCH_LOAD: begin
                ld_ir      = 1'b1;
                state_next = DECODE;
            end
            DECODE: begin
                ld_x = 1'b1;
                ld_y = 1'b1;
                ld_z = 1'b1;
                if (opcode == STOP) begin
                    state_next = HALT;
                end else if (is_arith || (is_mov && z_zero) ||
                             opcode == IN || opcode == OUT) begin
                    state_next = from_z;
                end else begin
                    // Unknown opcode or MOV with z set
                    state_next = NEXT;
                end
            end
            IND_Z: begin
                mar_sel     = MAR_Z;
                ld_mar      = 1'b1;
                addr_strobe = 1'b1;
                state_next  = IND_Z_WAIT;
            end
            IND_Z_WAIT: state_next = IND_Z_LOAD;
            IND_Z_LOAD: begin
                ld_z_mem   = 1'b1;
                state_next = from_y;
            end
            IND_Y: begin
                mar_sel     = MAR_Y;
                ld_mar      = 1'b1;
                addr_strobe = 1'b1;
                state_next  = IND_Y_WAIT;
            end
            IND_Y_WAIT: state_next = IND_Y_LOAD;
            IND_Y_LOAD: begin
                ld_y_mem   = 1'b1;
                state_next = from_x;
            end
            IND_X: begin
                mar_sel     = MAR_X;
                ld_mar      = 1'b1;
                addr_strobe = 1'b1;
                state_next  = IND_X_WAIT;
            end
            IND_X_WAIT: state_next = IND_X_LOAD;
            IND_X_LOAD: begin
                ld_x_mem   = 1'b1;
                state_next = ops_state;
            end
            LOAD_A: begin
                // OUT reads x, the others read y first
                mar_sel     = (opcode == OUT) ? MAR_X : MAR_Y;
                ld_mar      = 1'b1;
                addr_strobe = 1'b1;
                state_next  = LOAD_A_WAIT;
            end
            LOAD_A_WAIT: state_next = is_arith ? LOAD_B : EXECUTE;
            LOAD_B: begin
                ld_acc      = 1'b1;
                mar_sel     = MAR_Z;
                ld_mar      = 1'b1;
                addr_strobe = 1'b1;
                state_next  = LOAD_B_WAIT;
            end
            LOAD_B_WAIT: state_next = EXECUTE;
            EXECUTE: begin
                if (opcode == OUT) begin
                    out_strobe = 1'b1;
                    state_next = NEXT;
                end else begin
                    ld_y_alu   = is_arith;
                    ld_mdr_mem = is_mov;
                    state_next = WRITE;
                end
            end
            IN_WAIT: begin
                if (status && control) begin
                    ld_mdr_in  = 1'b1;
                    state_next = WRITE;
                end
            end
            WRITE: begin
                mar_sel      = MAR_X;
                ld_mar       = 1'b1;
                addr_strobe  = 1'b1;
                write_strobe = 1'b1;
                data_sel     = is_arith ? DATA_Y : DATA_MDR;
                state_next   = NEXT;
            end
            NEXT: state_next = prog_done ? HALT : FETCH;
            HALT: state_next = HALT;
            default: state_next = INIT;
        endcase
    end

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
    parameter int PROG_START = 8,
    parameter int PROG_END   = 24
) (
    input  logic           clk,
    input  logic           rst_n,
    input  cpu_pkg::data_t mem,
    input  cpu_pkg::data_t in,
    input  logic           control,
    output logic           we,
    output cpu_pkg::addr_t addr,
    output cpu_pkg::data_t data,
    output cpu_pkg::data_t out,
    output logic           out_valid,
    output logic           status,
    output cpu_pkg::addr_t pc,
    output logic           halted
);
    import cpu_pkg::*;

    logic          ld_pc, inc_pc, ld_mar, ld_mdr_mem, ld_mdr_in, ld_ir;
    logic          ld_x, ld_y, ld_z, ld_x_mem, ld_y_mem, ld_z_mem;
    logic          ld_acc, ld_y_alu;
    logic          addr_strobe, write_strobe, out_strobe;
    mar_sel_t      mar_sel;
    mem_data_sel_t data_sel;
    alu_op_t       alu_op;
    opcode_t       opcode;
    logic          mode_x, mode_y, mode_z, z_zero, prog_done;

    cpu_control cpu_control_i (
        .clk(clk), .rst_n(rst_n), .control(control), .opcode(opcode),
        .mode_x(mode_x), .mode_y(mode_y), .mode_z(mode_z), .z_zero(z_zero),
        .prog_done(prog_done), .ld_pc(ld_pc), .inc_pc(inc_pc), .ld_mar(ld_mar),
        .ld_mdr_mem(ld_mdr_mem), .ld_mdr_in(ld_mdr_in), .ld_ir(ld_ir),
        .ld_x(ld_x), .ld_y(ld_y), .ld_z(ld_z), .ld_x_mem(ld_x_mem),
        .ld_y_mem(ld_y_mem), .ld_z_mem(ld_z_mem), .ld_acc(ld_acc),
        .ld_y_alu(ld_y_alu), .mar_sel(mar_sel), .data_sel(data_sel),
        .alu_op(alu_op), .addr_strobe(addr_strobe), .write_strobe(write_strobe),
        .out_strobe(out_strobe), .status(status), .halted(halted)
    );

    cpu_datapath #(.PROG_START(PROG_START), .PROG_END(PROG_END)) cpu_datapath_i (
        .clk(clk), .rst_n(rst_n), .mem(mem), .in(in), .ld_pc(ld_pc),
        .inc_pc(inc_pc), .ld_mar(ld_mar), .ld_mdr_mem(ld_mdr_mem),
        .ld_mdr_in(ld_mdr_in), .ld_ir(ld_ir), .ld_x(ld_x), .ld_y(ld_y),
        .ld_z(ld_z), .ld_x_mem(ld_x_mem), .ld_y_mem(ld_y_mem), .ld_z_mem(ld_z_mem),
        .ld_acc(ld_acc), .ld_y_alu(ld_y_alu), .mar_sel(mar_sel),
        .data_sel(data_sel), .alu_op(alu_op), .addr_strobe(addr_strobe),
        .write_strobe(write_strobe), .out_strobe(out_strobe), .addr(addr),
        .data(data), .we(we), .out(out), .out_valid(out_valid), .pc(pc),
        .opcode(opcode), .mode_x(mode_x), .mode_y(mode_y), .mode_z(mode_z),
        .z_zero(z_zero), .prog_done(prog_done)
    );

endmodule

/* tb/cpu_props.sv */
`timescale 1ns/1ps

module cpu_props (
    input logic clk,
    input logic rst_n,
    input logic control,
    input logic status,
    input logic halted,
    input logic write_strobe,
    input logic out_strobe
);

    // we and out_valid follow these strobes by one cycle
    halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !$past(write_strobe) && !$past(out_strobe))
        else $error("we or out_valid high while halted");

    out_single: assert property (@(posedge clk) disable iff (!rst_n)
        out_strobe |=> !out_strobe)
        else $error("out_valid longer than one cycle");

    // IN wait ends only on a seen strobe
    status_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(status) |-> $past(control))
        else $error("status fell with no control strobe");

endmodule

bind cpu_control cpu_props cpu_props_i (
    .clk(clk),
    .rst_n(rst_n),
    .control(control),
    .status(status),
    .halted(halted),
    .write_strobe(write_strobe),
    .out_strobe(out_strobe)
);

/* tb/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
    import cpu_pkg::*;

    localparam int PROG_START  = 8;
    localparam int PROG_END    = 24;
    localparam int NUM_TESTS   = 8;
    localparam int MAX_IN_DLY  = 16;
    // Per test: 16 instructions of up to 40 cycles, IN delays, reset and tail
    localparam int WATCHDOG_NS = NUM_TESTS * (16 * 40 + 16 * MAX_IN_DLY + 40) * 20;

    logic   clk      = 1'b0;
    logic   rst_n    = 1'b0;
    logic   control  = 1'b0;
    logic   load_req = 1'b0;
    data_t  in_word  = '0;
    data_t  mem_rd   = '0;
    logic   we;
    logic   out_valid;
    logic   status;
    logic   halted;
    addr_t  addr;
    addr_t  pc;
    data_t  wr_data;
    data_t  out_word;

    integer seed = 32'hdb13_7c9e;
    data_t  ram [0:63];
    data_t  init_mem [0:63];
    data_t  ref_mem [0:63];
    data_t  in_vals [0:15];
    int     in_dly [0:15];
    data_t  exp_outs [$];
    data_t  out_got [$];
    int     in_idx = 0;
    int     wait_cnt = 0;
    int     idle_cnt = 0;
    int     exp_in_count;
    addr_t  exp_pc;
    int     error_count = 0;
    int     tests_failed = 0;
    logic [3:0] io_ops [0:3] = '{IN, OUT, ADD, MOV};
    string  kind_name [0:3] = '{"direct", "indirect", "io", "stop"};

    initial begin
        forever #10 clk = ~clk;
    end

    cpu_top cpu_top_i (
        .clk(clk), .rst_n(rst_n), .mem(mem_rd), .in(in_word), .control(control),
        .we(we), .addr(addr), .data(wr_data), .out(out_word), .out_valid(out_valid),
        .status(status), .pc(pc), .halted(halted)
    );

    // Synchronous read memory, one cycle of latency
    always @(posedge clk) begin
        if (load_req) begin
            for (int i = 0; i < 64; i++) begin
                ram[i] <= init_mem[i];
            end
        end else if (we) begin
            ram[addr] <= wr_data;
        end
        mem_rd <= ram[addr];
    end

    task automatic check_value(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // Answers IN after a random delay, and strobes now and then while status is low
    always @(negedge clk) begin
        if (!rst_n || halted) begin
            control = 1'b0;
            if (!rst_n) begin
                in_idx   = 0;
                wait_cnt = 0;
            end
        end else if (control) begin
            control = 1'b0;
        end else if (status && in_idx < 16) begin
            if (wait_cnt >= in_dly[in_idx]) begin
                in_word  = in_vals[in_idx];
                control  = 1'b1;
                in_idx++;
                wait_cnt = 0;
            end else begin
                wait_cnt++;
            end
        end else begin
            idle_cnt++;
            if (idle_cnt % 7 == 0) begin
                in_word = ~in_word;
                control = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            out_got.delete();
        end else begin
            if (out_valid) begin
                out_got.push_back(out_word);
            end
            if (halted) begin
                check_value("we while halted", data_t'(we), '0);
                check_value("out_valid while halted", data_t'(out_valid), '0);
            end
        end
    end

    task automatic build_test(input int kind);
        integer r;
        data_t  w;
        int     ptr;
        int     stop_pos;
        stop_pos = 10 + int'({$random(seed)} % 12);
        for (int a = 0; a < 64; a++) begin
            r = $random(seed);
            if (a < PROG_START) begin
                // Pointer words aim above the program
                ptr = PROG_END + int'(r[25:16]) % 40;
                init_mem[a] = {r[15:6], ptr[5:0]};
            end else if (a >= PROG_END) begin
                init_mem[a] = r[15:0];
            end else begin
                w = r[15:0];
                case (kind)
                    0: begin
                        w[15:12] = {2'b00, r[17:16]};
                        w[11]    = 1'b0;
                        w[7]     = 1'b0;
                        w[3]     = 1'b0;
                    end
                    1: w[15:12] = {2'b00, r[17:16]};
                    2: w[15:12] = io_ops[r[17:16]];
                    default: begin
                        w[15:12] = r[19:16];
                        if (a == stop_pos) begin
                            w[15:12] = STOP;
                        end
                    end
                endcase
                // The stop program keeps MOV with z set as a no-op
                if (w[15:12] == MOV && kind != 3) begin
                    w[3:0] = 4'h0;
                end
                init_mem[a] = w;
            end
        end
        for (int k = 0; k < 16; k++) begin
            in_vals[k] = data_t'($random(seed));
            in_dly[k]  = int'({$random(seed)} % MAX_IN_DLY);
        end
    endtask

    // Instruction-level model of the same program
    task automatic run_model();
        int          p;
        data_t       w;
        addr_t       xa;
        addr_t       ya;
        addr_t       za;
        logic [31:0] prod;
        logic        stopped;
        p = PROG_START;
        stopped = 1'b0;
        exp_outs.delete();
        exp_in_count = 0;
        foreach (init_mem[i]) begin
            ref_mem[i] = init_mem[i];
        end
        while (p != PROG_END && !stopped) begin
            w = ref_mem[p];
            p++;
            xa = w[11] ? ref_mem[w[10:8]][5:0] : addr_t'(w[10:8]);
            ya = w[7] ? ref_mem[w[6:4]][5:0] : addr_t'(w[6:4]);
            za = w[3] ? ref_mem[w[2:0]][5:0] : addr_t'(w[2:0]);
            prod = {16'h0, ref_mem[ya]} * {16'h0, ref_mem[za]};
            case (w[15:12])
                MOV: begin
                    if (w[3:0] == 4'h0) begin
                        ref_mem[xa] = ref_mem[ya];
                    end
                end
                ADD: ref_mem[xa] = ref_mem[ya] + ref_mem[za];
                SUB: ref_mem[xa] = ref_mem[ya] - ref_mem[za];
                MUL: ref_mem[xa] = prod[15:0];
                IN: begin
                    ref_mem[xa] = in_vals[exp_in_count];
                    exp_in_count++;
                end
                OUT: exp_outs.push_back(ref_mem[xa]);
                STOP: stopped = 1'b1;
                default: ;
            endcase
        end
        exp_pc = addr_t'(p);
    endtask

    task automatic run_test(input int t, input int kind);
        int errs_before;
        errs_before = error_count;
        rst_n = 1'b0;
        build_test(kind);
        run_model();
        load_req = 1'b1;
        @(negedge clk);
        load_req = 1'b0;
        repeat (4) @(negedge clk);
        check_value("we in reset", data_t'(we), '0);
        check_value("status in reset", data_t'(status), '0);
        check_value("out_valid in reset", data_t'(out_valid), '0);
        check_value("halted in reset", data_t'(halted), '0);
        check_value("pc in reset", data_t'(pc), data_t'(PROG_START));
        rst_n = 1'b1;
        while (!halted) begin
            @(negedge clk);
        end
        // Idle a little so late writes or pulses show up
        repeat (4) @(negedge clk);
        check_value("pc at halt", data_t'(pc), data_t'(exp_pc));
        check_value("IN strobes taken", data_t'(in_idx), data_t'(exp_in_count));
        check_value("out_valid pulses", data_t'(out_got.size()), data_t'(exp_outs.size()));
        for (int i = 0; i < exp_outs.size() && i < out_got.size(); i++) begin
            check_value($sformatf("out[%0d]", i), out_got[i], exp_outs[i]);
        end
        for (int a = 0; a < 64; a++) begin
            check_value($sformatf("mem[%0d]", a), ram[a], ref_mem[a]);
        end
        if (error_count != errs_before) begin
            tests_failed++;
        end
        $display("Test %0d, %s program: %s", t, kind_name[kind],
                 (error_count == errs_before) ? "passed" : "failed");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the CPU did not finish all programs within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        @(negedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t, t % 4);
        end
        $display("Tests run %0d, passed %0d, failed %0d, mismatches %0d", NUM_TESTS,
                 NUM_TESTS - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
rtl/cpu_pkg.sv
rtl/cpu_datapath.sv
rtl/cpu_control.sv
rtl/cpu_top.sv
tb/cpu_props.sv
tb/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f project.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
grep -q "STATUS: PASS" sim.log
